//--- common/core_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I encodings for the integer ALU subset, OP and OP-IMM only.
// The instruction word is seen as R-type or I-type; S/B/U/J are not decoded.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int REG_COUNT     = 32;
    localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // Major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes, shared by OP and OP-IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA/SRAI.

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
    } insn_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

//--- common/uarch_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core sizing. ROB_DEPTH must be a power of two, pointers wrap by overflow.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uarch_pkg;

    localparam int ROB_DEPTH     = 8;
    localparam int ROB_TAG_WIDTH = $clog2(ROB_DEPTH);

    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // Cycles from dispatch to the CDB.
    localparam int EXEC_STAGES = 2;

endpackage

//--- hdl/insn_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational decode and operand fetch. Any opcode other than OP-IMM is
// treated as OP. Stalls until both sources have a value.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module insn_decode (
    input  logic                i_insn_valid,
    input  core_pkg::insn_t     i_insn,
    input  logic                i_rob_full,
    input  logic                i_rat_pending [2],
    input  core_pkg::data_t     i_rat_data [2],
    input  uarch_pkg::rob_tag_t i_rat_tag [2],
    input  logic                i_rob_done [2],
    input  core_pkg::data_t     i_rob_data [2],
    output logic                o_decode_stall,
    output core_pkg::reg_idx_t  o_rsrc [2],
    output uarch_pkg::rob_tag_t o_lookup_tag [2],
    output logic                o_dispatch_en,
    output core_pkg::reg_idx_t  o_rdst,
    output core_pkg::alu_op_t   o_alu_op,
    output core_pkg::data_t     o_src_a,
    output core_pkg::data_t     o_src_b
);
    logic            is_imm;
    logic [2:0]      funct3;
    logic            alt;
    core_pkg::data_t imm;
    core_pkg::data_t operand [2];
    logic [1:0]      blocked;

    // rd, rs1, funct3 and funct7 sit at the same bits in both views.
    assign is_imm = (i_insn.i.opcode == core_pkg::OPC_OP_IMM);
    assign funct3 = i_insn.r.funct3;
    assign alt    = (i_insn.r.funct7 == core_pkg::F7_ALT);

    assign o_rdst    = i_insn.r.rd;
    assign o_rsrc[0] = i_insn.r.rs1;
    assign o_rsrc[1] = is_imm ? '0 : i_insn.r.rs2; // x0 is never pending.

    always_comb begin
        case (funct3)
            core_pkg::F3_ADD_SUB: o_alu_op = (alt && !is_imm) ? core_pkg::ALU_SUB
                                                               : core_pkg::ALU_ADD;
            core_pkg::F3_SLL:     o_alu_op = core_pkg::ALU_SLL;
            core_pkg::F3_SLT:     o_alu_op = core_pkg::ALU_SLT;
            core_pkg::F3_SLTU:    o_alu_op = core_pkg::ALU_SLTU;
            core_pkg::F3_XOR:     o_alu_op = core_pkg::ALU_XOR;
            core_pkg::F3_SR:      o_alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            core_pkg::F3_OR:      o_alu_op = core_pkg::ALU_OR;
            default:              o_alu_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        if (funct3 == core_pkg::F3_SLL || funct3 == core_pkg::F3_SR) begin
            imm = core_pkg::data_t'(i_insn.i.imm12[4:0]); // Shift amount only.
        end else begin
            imm = {{(core_pkg::DATA_WIDTH-12){i_insn.i.imm12[11]}}, i_insn.i.imm12};
        end
    end

    // A pending source takes the ROB value once it is done.
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_lookup_tag[k] = i_rat_tag[k];
            operand[k]      = i_rat_pending[k] ? i_rob_data[k] : i_rat_data[k];
            blocked[k]      = i_rat_pending[k] & ~i_rob_done[k];
        end
    end

    assign o_decode_stall = i_insn_valid & (|blocked);
    assign o_dispatch_en  = i_insn_valid & ~o_decode_stall & ~i_rob_full;

    assign o_src_a = operand[0];
    assign o_src_b = is_imm ? imm : operand[1];

endmodule

//--- hdl/rename_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural registers with a pending ROB tag each. x0 is never written
// or renamed. A rename beats a retire clear to the same register.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rename_table (
    input  logic                clk,
    input  logic                i_rst,
    input  core_pkg::reg_idx_t  i_rsrc [2],
    input  logic                i_rename_en,
    input  core_pkg::reg_idx_t  i_rename_rdst,
    input  uarch_pkg::rob_tag_t i_rename_tag,
    input  logic                i_retire_en,
    input  core_pkg::reg_idx_t  i_retire_rdst,
    input  uarch_pkg::rob_tag_t i_retire_tag,
    input  core_pkg::data_t     i_retire_data,
    output logic                o_pending [2],
    output core_pkg::data_t     o_data [2],
    output uarch_pkg::rob_tag_t o_tag [2]
);
    core_pkg::data_t               reg_data [core_pkg::REG_COUNT];
    logic [core_pkg::REG_COUNT-1:0] reg_pending;
    uarch_pkg::rob_tag_t           reg_tag [core_pkg::REG_COUNT];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_pending[k] = reg_pending[i_rsrc[k]];
            o_data[k]    = reg_data[i_rsrc[k]];
            o_tag[k]     = reg_tag[i_rsrc[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            reg_pending <= '0;
            for (int r = 0; r < core_pkg::REG_COUNT; r++) begin
                reg_data[r] <= '0;
            end
        end else begin
            if (i_retire_en && i_retire_rdst != '0) begin
                reg_data[i_retire_rdst] <= i_retire_data;
            end
            for (int r = 1; r < core_pkg::REG_COUNT; r++) begin
                if (i_rename_en && i_rename_rdst == core_pkg::reg_idx_t'(r)) begin
                    reg_pending[r] <= 1'b1;
                end else if (i_retire_en && i_retire_rdst == core_pkg::reg_idx_t'(r) &&
                             reg_tag[r] == i_retire_tag) begin
                    reg_pending[r] <= 1'b0; // Youngest writer retired.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rename_en && i_rename_rdst != '0) begin
            reg_tag[i_rename_rdst] <= i_rename_tag;
        end
    end

endmodule

//--- rob/reorder_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular reorder buffer. One allocation and one retirement per cycle.
// Retire outputs are registered, a done head leaves on the next edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_dispatch_en,
    input  core_pkg::reg_idx_t  i_dispatch_rdst,
    input  logic                i_cdb_en,
    input  uarch_pkg::rob_tag_t i_cdb_tag,
    input  core_pkg::data_t     i_cdb_data,
    input  uarch_pkg::rob_tag_t i_lookup_tag [2],
    output uarch_pkg::rob_tag_t o_tail_tag,
    output logic                o_full,
    output logic                o_lookup_done [2],
    output core_pkg::data_t     o_lookup_data [2],
    output logic                o_retire_en,
    output core_pkg::reg_idx_t  o_retire_rdst,
    output uarch_pkg::rob_tag_t o_retire_tag,
    output core_pkg::data_t     o_retire_data
);
    logic [uarch_pkg::ROB_DEPTH-1:0] entry_valid;
    logic [uarch_pkg::ROB_DEPTH-1:0] entry_done;
    core_pkg::reg_idx_t              entry_rdst [uarch_pkg::ROB_DEPTH];
    core_pkg::data_t                 entry_data [uarch_pkg::ROB_DEPTH];

    uarch_pkg::rob_tag_t              head;
    uarch_pkg::rob_tag_t              tail;
    logic [uarch_pkg::ROB_TAG_WIDTH:0] count;
    logic                             retire_go;

    assign retire_go  = entry_valid[head] & entry_done[head];
    assign o_full     = (count == uarch_pkg::ROB_DEPTH);
    assign o_tail_tag = tail;

    // Same-cycle CDB result is forwarded to the lookup.
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (i_cdb_en && i_cdb_tag == i_lookup_tag[k]) begin
                o_lookup_done[k] = 1'b1;
                o_lookup_data[k] = i_cdb_data;
            end else begin
                o_lookup_done[k] = entry_done[i_lookup_tag[k]];
                o_lookup_data[k] = entry_data[i_lookup_tag[k]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            entry_valid <= '0;
            entry_done  <= '0;
            o_retire_en <= 1'b0;
        end else begin
            if (i_dispatch_en) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail]  <= 1'b0;
                tail              <= tail + 1'b1;
            end
            if (i_cdb_en) begin
                entry_done[i_cdb_tag] <= 1'b1;
            end
            if (retire_go) begin
                entry_valid[head] <= 1'b0; // Done bit stays for late lookups.
                head              <= head + 1'b1;
            end
            o_retire_en <= retire_go;

            case ({i_dispatch_en, retire_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_dispatch_en) begin
            entry_rdst[tail] <= i_dispatch_rdst;
        end
        if (i_cdb_en) begin
            entry_data[i_cdb_tag] <= i_cdb_data;
        end
        if (retire_go) begin
            o_retire_rdst <= entry_rdst[head];
            o_retire_tag  <= head;
            o_retire_data <= entry_data[head];
        end
    end

endmodule

//--- hdl/int_exec_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined integer ALU, fixed latency of EXEC_STAGES (at least 2), no
// back-pressure. Accepts one operation every cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module int_exec_unit (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  core_pkg::alu_op_t   i_alu_op,
    input  core_pkg::data_t     i_src_a,
    input  core_pkg::data_t     i_src_b,
    input  uarch_pkg::rob_tag_t i_tag,
    output logic                o_cdb_en,
    output uarch_pkg::rob_tag_t o_cdb_tag,
    output core_pkg::data_t     o_cdb_data
);
    logic [uarch_pkg::EXEC_STAGES-1:0] vld_q;
    uarch_pkg::rob_tag_t               tag_q [uarch_pkg::EXEC_STAGES];
    core_pkg::alu_op_t                 op_q;
    core_pkg::data_t                   a_q;
    core_pkg::data_t                   b_q;
    core_pkg::data_t                   res_q [uarch_pkg::EXEC_STAGES-1];
    core_pkg::data_t                   alu_res;
    logic [4:0]                        shamt;

    assign shamt = b_q[4:0];

    always_comb begin
        case (op_q)
            core_pkg::ALU_ADD:  alu_res = a_q + b_q;
            core_pkg::ALU_SUB:  alu_res = a_q - b_q;
            core_pkg::ALU_SLL:  alu_res = a_q << shamt;
            core_pkg::ALU_SLT:  alu_res = core_pkg::data_t'($signed(a_q) < $signed(b_q));
            core_pkg::ALU_SLTU: alu_res = core_pkg::data_t'(a_q < b_q);
            core_pkg::ALU_XOR:  alu_res = a_q ^ b_q;
            core_pkg::ALU_SRL:  alu_res = a_q >> shamt;
            core_pkg::ALU_SRA:  alu_res = $signed(a_q) >>> shamt;
            core_pkg::ALU_OR:   alu_res = a_q | b_q;
            core_pkg::ALU_AND:  alu_res = a_q & b_q;
            default:            alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[uarch_pkg::EXEC_STAGES-2:0], i_valid};
        end
    end

    always_ff @(posedge clk) begin
        op_q     <= i_alu_op; // Stage 1.
        a_q      <= i_src_a;
        b_q      <= i_src_b;
        tag_q[0] <= i_tag;
        res_q[0] <= alu_res;  // Stage 2.
        for (int s = 1; s < uarch_pkg::EXEC_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
        for (int s = 1; s < uarch_pkg::EXEC_STAGES - 1; s++) begin
            res_q[s] <= res_q[s-1];
        end
    end

    assign o_cdb_en   = vld_q[uarch_pkg::EXEC_STAGES-1];
    assign o_cdb_tag  = tag_q[uarch_pkg::EXEC_STAGES-1];
    assign o_cdb_data = res_q[uarch_pkg::EXEC_STAGES-2];

endmodule

//--- hdl/ooo_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order integer core. Accepts OP/OP-IMM only. Hold i_insn while
// o_insn_stall is high; every instruction retires through o_retire_en.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ooo_core (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_insn_valid,
    input  core_pkg::insn_t    i_insn,
    output logic               o_insn_stall,
    output logic               o_retire_en,
    output core_pkg::reg_idx_t o_retire_rdst,
    output core_pkg::data_t    o_retire_data
);
    logic                decode_stall;
    logic                dispatch_en;
    core_pkg::reg_idx_t  dispatch_rdst;
    core_pkg::alu_op_t   dispatch_op;
    core_pkg::data_t     dispatch_src_a;
    core_pkg::data_t     dispatch_src_b;

    core_pkg::reg_idx_t  rat_rsrc [2];
    logic                rat_pending [2];
    core_pkg::data_t     rat_data [2];
    uarch_pkg::rob_tag_t rat_tag [2];

    uarch_pkg::rob_tag_t lookup_tag [2];
    logic                rob_done [2];
    core_pkg::data_t     rob_data [2];
    uarch_pkg::rob_tag_t rob_tail_tag;
    logic                rob_full;

    logic                cdb_en;
    uarch_pkg::rob_tag_t cdb_tag;
    core_pkg::data_t     cdb_data;

    uarch_pkg::rob_tag_t retire_tag;

    assign o_insn_stall = decode_stall | rob_full;

    insn_decode insn_decode_i (
        .i_insn_valid   (i_insn_valid),
        .i_insn         (i_insn),
        .i_rob_full     (rob_full),
        .i_rat_pending  (rat_pending),
        .i_rat_data     (rat_data),
        .i_rat_tag      (rat_tag),
        .i_rob_done     (rob_done),
        .i_rob_data     (rob_data),
        .o_decode_stall (decode_stall),
        .o_rsrc         (rat_rsrc),
        .o_lookup_tag   (lookup_tag),
        .o_dispatch_en  (dispatch_en),
        .o_rdst         (dispatch_rdst),
        .o_alu_op       (dispatch_op),
        .o_src_a        (dispatch_src_a),
        .o_src_b        (dispatch_src_b)
    );

    rename_table rename_table_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_rsrc        (rat_rsrc),
        .i_rename_en   (dispatch_en),
        .i_rename_rdst (dispatch_rdst),
        .i_rename_tag  (rob_tail_tag),
        .i_retire_en   (o_retire_en),
        .i_retire_rdst (o_retire_rdst),
        .i_retire_tag  (retire_tag),
        .i_retire_data (o_retire_data),
        .o_pending     (rat_pending),
        .o_data        (rat_data),
        .o_tag         (rat_tag)
    );

    reorder_buffer reorder_buffer_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_dispatch_en   (dispatch_en),
        .i_dispatch_rdst (dispatch_rdst),
        .i_cdb_en        (cdb_en),
        .i_cdb_tag       (cdb_tag),
        .i_cdb_data      (cdb_data),
        .i_lookup_tag    (lookup_tag),
        .o_tail_tag      (rob_tail_tag),
        .o_full          (rob_full),
        .o_lookup_done   (rob_done),
        .o_lookup_data   (rob_data),
        .o_retire_en     (o_retire_en),
        .o_retire_rdst   (o_retire_rdst),
        .o_retire_tag    (retire_tag),
        .o_retire_data   (o_retire_data)
    );

    int_exec_unit int_exec_unit_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_valid    (dispatch_en),
        .i_alu_op   (dispatch_op),
        .i_src_a    (dispatch_src_a),
        .i_src_b    (dispatch_src_b),
        .i_tag      (rob_tail_tag),
        .o_cdb_en   (cdb_en),
        .o_cdb_tag  (cdb_tag),
        .o_cdb_data (cdb_data)
    );

endmodule

//--- verif/ooo_core_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for ooo_core. Plays OP/OP-IMM words from the golden file with
// random idle gaps and checks every retirement in program order.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 2;
    localparam int          MAX_ENTRIES  = 64;
    localparam int          DRAIN_CYCLES = 2 * uarch_pkg::ROB_DEPTH;
    localparam logic [31:0] LFSR_SEED    = 32'he69d_33b8;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic               clk;
    logic               i_rst;
    logic               i_insn_valid;
    core_pkg::insn_t    i_insn;
    logic               o_insn_stall;
    logic               o_retire_en;
    core_pkg::reg_idx_t o_retire_rdst;
    core_pkg::data_t    o_retire_data;

    // Three words per entry: instruction, rdst, data.
    logic [31:0] golden_mem [0:3*MAX_ENTRIES-1];
    int          num_entries     = 0;
    int          accepted_count  = 0;
    int          retire_count    = 0;
    int          value_errors    = 0;
    int          protocol_errors = 0;
    logic [31:0] lfsr_state      = LFSR_SEED;

    ooo_core dut_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_insn_valid  (i_insn_valid),
        .i_insn        (i_insn),
        .o_insn_stall  (o_insn_stall),
        .o_retire_en   (o_retire_en),
        .o_retire_rdst (o_retire_rdst),
        .o_retire_data (o_retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // Idle cycles before the next instruction, 0 to 3.
    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            bits[b]    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        gap = int'(bits);
    endtask

    task automatic compare_reg(input string name, input core_pkg::reg_idx_t expected,
                               input core_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_data(input string name, input core_pkg::data_t expected,
                                input core_pkg::data_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // Presents each word and holds it while the core stalls.
    task automatic drive_program();
        int   next_idx;
        int   gap;
        logic holding;
        next_idx = 0;
        gap      = 0;
        holding  = 1'b0;
        while (next_idx < num_entries || holding) begin
            @(posedge clk);
            if (holding && !o_insn_stall) begin
                accepted_count++;
                draw_gap(gap);
                holding = 1'b0;
            end else if (!holding && gap > 0) begin
                gap--;
            end
            if (!holding) begin
                if (gap == 0 && next_idx < num_entries) begin
                    i_insn_valid <= 1'b1;
                    i_insn       <= core_pkg::insn_t'(golden_mem[3*next_idx]);
                    next_idx++;
                    holding = 1'b1;
                end else begin
                    i_insn_valid <= 1'b0;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!i_rst) begin
            if ($isunknown(o_retire_en)) begin
                protocol_errors++;
                $display("o_retire_en is unknown after reset");
            end else if (o_retire_en) begin
                if (retire_count >= accepted_count) begin
                    protocol_errors++;
                    $display("Retirement %0d seen with no dispatched instruction left",
                             retire_count);
                end else begin
                    compare_reg($sformatf("insn %0d rdst", retire_count),
                                core_pkg::reg_idx_t'(golden_mem[3*retire_count+1]),
                                o_retire_rdst);
                    compare_data($sformatf("insn %0d data", retire_count),
                                 core_pkg::data_t'(golden_mem[3*retire_count+2]),
                                 o_retire_data);
                end
                retire_count++;
            end
        end
    end

    // Budget of 16 cycles per entry plus reset.
    initial begin
        wait (num_entries > 0);
        #((num_entries * (8 + uarch_pkg::ROB_DEPTH) + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d retirements arrived, the run did not finish",
                 retire_count, num_entries);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        i_rst        = 1'b1;
        i_insn_valid = 1'b0;
        i_insn       = '0;
        $readmemh("verif/ooo_core_golden.txt", golden_mem);
        while (num_entries < MAX_ENTRIES && !$isunknown(golden_mem[3*num_entries])) begin
            num_entries++;
        end
        if (num_entries == 0) begin
            $display("The golden file is missing or holds no entries");
            $display("Test FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            i_rst <= 1'b0;
            drive_program();
            while (retire_count < num_entries) begin
                @(posedge clk);
            end
            repeat (DRAIN_CYCLES) @(posedge clk); // Catch extra retirements.
            $display("Retired %0d of %0d, value errors %0d, protocol errors %0d",
                     retire_count, num_entries, value_errors, protocol_errors);
            if (value_errors == 0 && protocol_errors == 0 && retire_count == num_entries) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verif/ooo_core_golden.txt
// Columns: instruction word, expected retire rdst, expected retire data (hex).
// One instruction per line, in program order; registers start at zero.
12300093 01 00000123
FFB00113 02 FFFFFFFB
002081B3 03 0000011E
40208233 04 00000128
0041F2B3 05 00000108
0041E333 06 0000013E
0041C3B3 07 00000036
00112433 08 00000001
001134B3 09 00000000
00809533 0A 00000246
007155B3 0B 000003FF
40815633 0C FFFFFFFD
FFC12693 0D 00000001
FFF0B713 0E 00000001
7FF0C793 0F 000006DC
F000E093 01 FFFFFF23
0F00F813 10 00000020
00479893 11 00006DC0
0080D913 12 00FFFFFF
4080D993 13 FFFFFFFF

//--- flist.f
common/core_pkg.sv
common/uarch_pkg.sv
hdl/insn_decode.sv
hdl/rename_table.sv
rob/reorder_buffer.sv
hdl/int_exec_unit.sv
hdl/ooo_core.sv
verif/ooo_core_tb.sv
